// File: source/mrd_bank.sv
// ----------------------------------------------------------------------
// one ping-pong frame bank
// frame register array
// sink, compute and source sequencer
// butterfly job issue and result writeback
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mrd_bank #(
	parameter int DATA_W    = mrd_cfg_pkg::DATA_W,
	parameter int FRAME_PTS = mrd_cfg_pkg::FRAME_PTS,
	parameter bit BANK_ID   = 1'b0
) (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire mrd_ctrl_pkg::bank_ctrl_t ctrl,
	output mrd_ctrl_pkg::bank_stat_t      stat,
	output mrd_ctrl_pkg::bank_phase_e     phase,
	input  wire logic                     in_valid,
	input  wire logic                     in_sop,
	input  wire mrd_cfg_pkg::sample_t     in_data,
	output logic                          req_valid,
	output mrd_cfg_pkg::bfly_req_t        req,
	input  wire logic                     grant,
	input  wire logic                     rsp_valid,
	input  wire mrd_cfg_pkg::bfly_rsp_t   rsp,
	output logic                          out_valid,
	output logic                          out_sop,
	output mrd_cfg_pkg::sample_t          out_data
);

	localparam int IDX_W  = $clog2(FRAME_PTS);
	localparam int PAIR_W = IDX_W - 1;
	localparam int NPAIRS = FRAME_PTS / 2;

	logic signed [DATA_W-1:0] mem [FRAME_PTS];

	// sink write and source read pointers
	logic [IDX_W-1:0]  wr_idx;
	logic [IDX_W-1:0]  rd_idx;
	// next pair to issue, and results written back so far
	logic [PAIR_W-1:0] iss_pair;
	logic [PAIR_W-1:0] wb_cnt;
	logic              all_issued;
	logic              sink_done_q;
	logic              sink_first;
	logic              sink_wr;
	logic              src_last;

	// first sample only counts with in_sop, stray samples in IDLE are dropped
	assign sink_first = (phase == mrd_ctrl_pkg::IDLE) & ctrl.sink_sel & in_valid & in_sop;
	assign sink_wr    = sink_first |
	                    ((phase == mrd_ctrl_pkg::SINK) & ctrl.sink_sel & in_valid);
	assign src_last   = rd_idx == IDX_W'(FRAME_PTS - 1);

	// ------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase       <= mrd_ctrl_pkg::IDLE;
			wr_idx      <= '0;
			rd_idx      <= '0;
			iss_pair    <= '0;
			wb_cnt      <= '0;
			all_issued  <= 1'b0;
			sink_done_q <= 1'b0;
		end else begin
			sink_done_q <= 1'b0;
			// wr_idx rests at 0 between frames, it wraps after the last sample
			if (sink_wr) begin
				wr_idx <= wr_idx + 1'b1;
			end
			case (phase)
				mrd_ctrl_pkg::IDLE: begin
					if (sink_first) begin
						phase <= mrd_ctrl_pkg::SINK;
					end
				end
				mrd_ctrl_pkg::SINK: begin
					if (sink_wr && wr_idx == IDX_W'(FRAME_PTS - 1)) begin
						phase       <= mrd_ctrl_pkg::COMPUTE;
						sink_done_q <= 1'b1;
						iss_pair    <= '0;
						wb_cnt      <= '0;
						all_issued  <= 1'b0;
					end
				end
				mrd_ctrl_pkg::COMPUTE: begin
					// next pair goes up right after a grant
					if (grant) begin
						iss_pair <= iss_pair + 1'b1;
						if (iss_pair == PAIR_W'(NPAIRS - 1)) begin
							all_issued <= 1'b1;
						end
					end
					if (rsp_valid) begin
						wb_cnt <= wb_cnt + 1'b1;
						if (wb_cnt == PAIR_W'(NPAIRS - 1)) begin
							phase <= mrd_ctrl_pkg::READY;
						end
					end
				end
				mrd_ctrl_pkg::READY: begin
					if (ctrl.source_go) begin
						phase  <= mrd_ctrl_pkg::SOURCE;
						rd_idx <= '0;
					end
				end
				mrd_ctrl_pkg::SOURCE: begin
					rd_idx <= rd_idx + 1'b1;
					if (src_last) begin
						phase <= mrd_ctrl_pkg::IDLE;
					end
				end
				default: phase <= mrd_ctrl_pkg::IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// frame memory, written by the sink and by result writeback
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sink_wr) begin
			mem[wr_idx] <= in_data;
		end
		// sum to the even slot, diff to the odd slot
		if (rsp_valid) begin
			mem[{rsp.pair, 1'b0}] <= rsp.sum;
			mem[{rsp.pair, 1'b1}] <= rsp.diff;
		end
	end

	// job stays steady until granted, its slots are not written before then
	assign req_valid = (phase == mrd_ctrl_pkg::COMPUTE) & ~all_issued;
	assign req.a     = mem[{iss_pair, 1'b0}];
	assign req.b     = mem[{iss_pair, 1'b1}];
	assign req.pair  = iss_pair;
	assign req.bank  = BANK_ID;

	// output is zero outside SOURCE so the top can OR both banks
	assign out_valid = phase == mrd_ctrl_pkg::SOURCE;
	assign out_sop   = out_valid & (rd_idx == '0);
	assign out_data  = out_valid ? mem[rd_idx] : '0;

	assign stat.sink_sop     = sink_first;
	assign stat.sink_done    = sink_done_q;
	assign stat.ready        = phase == mrd_ctrl_pkg::READY;
	assign stat.source_start = out_sop;
	assign stat.source_end   = out_valid & src_last;

endmodule

`default_nettype wire

// File: source/mrd_bfly_arbiter.sv
// ----------------------------------------------------------------------
// round-robin arbiter for the shared butterfly engine
// one grant per cycle, priority flips when both banks request
// response strobe steered back by the bank tag
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mrd_bfly_arbiter (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   req_valid0,
	input  wire logic                   req_valid1,
	input  wire mrd_cfg_pkg::bfly_req_t req0,
	input  wire mrd_cfg_pkg::bfly_req_t req1,
	output logic                        grant0,
	output logic                        grant1,
	output logic                        eng_valid,
	output mrd_cfg_pkg::bfly_req_t      eng_req,
	input  wire logic                   eng_rsp_valid,
	input  wire mrd_cfg_pkg::bfly_rsp_t eng_rsp,
	output logic                        rsp_valid0,
	output logic                        rsp_valid1,
	output mrd_cfg_pkg::bfly_rsp_t      rsp
);

	// bank that wins the next tie
	logic rr_q;

	// a lone request always wins, a tie goes to rr_q
	assign grant0 = req_valid0 & (~req_valid1 | ~rr_q);
	assign grant1 = req_valid1 & (~req_valid0 | rr_q);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_q <= 1'b0;
		end else if (req_valid0 && req_valid1) begin
			rr_q <= ~rr_q;
		end
	end

	// granted job goes to the engine in the same cycle
	assign eng_valid = grant0 | grant1;
	assign eng_req   = grant1 ? req1 : req0;

	// results return to the bank named in the tag
	assign rsp_valid0 = eng_rsp_valid & ~eng_rsp.bank;
	assign rsp_valid1 = eng_rsp_valid & eng_rsp.bank;
	assign rsp        = eng_rsp;

endmodule

`default_nettype wire

// File: source/mrd_bfly_engine.sv
// ----------------------------------------------------------------------
// shared radix-2 butterfly engine
// stage 1 registers the operands and tag
// stage 2 registers sum and difference, wrapping at the sample width
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mrd_bfly_engine #(
	parameter int DATA_W = mrd_cfg_pkg::DATA_W
) (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   req_valid,
	input  wire mrd_cfg_pkg::bfly_req_t req,
	output logic                        rsp_valid,
	output mrd_cfg_pkg::bfly_rsp_t      rsp
);

	// stage 1 operand and tag registers
	logic signed [DATA_W-1:0] a_q;
	logic signed [DATA_W-1:0] b_q;
	mrd_cfg_pkg::pair_idx_t   pair_q;
	logic                     bank_q;
	logic                     v1_q;

	// valid pipe, one bit per stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1_q      <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			v1_q      <= req_valid;
			rsp_valid <= v1_q;
		end
	end

	// payload pipe, free running
	always_ff @(posedge clk) begin
		a_q      <= req.a;
		b_q      <= req.b;
		pair_q   <= req.pair;
		bank_q   <= req.bank;
		// sum and diff drop the carry, so they wrap
		rsp.sum  <= a_q + b_q;
		rsp.diff <= a_q - b_q;
		rsp.pair <= pair_q;
		rsp.bank <= bank_q;
	end

endmodule

`default_nettype wire

// File: source/mrd_cfg_pkg.sv
// ----------------------------------------------------------------------
// frame configuration for the ping-pong radix-2 processor
// default sample width and frame length
// sample, pair index and butterfly job / result types
// ----------------------------------------------------------------------

`default_nettype none

package mrd_cfg_pkg;

	// default sample width in bits
	parameter int DATA_W = 16;

	// default points per frame, power of two
	parameter int FRAME_PTS = 16;

	// one pair index covers FRAME_PTS/2 butterflies
	parameter int PAIR_W = $clog2(FRAME_PTS / 2);

	typedef logic signed [DATA_W-1:0] sample_t;

	typedef logic [PAIR_W-1:0] pair_idx_t;

	// one butterfly job, tagged with the issuing bank
	typedef struct packed {
		sample_t   a;
		sample_t   b;
		pair_idx_t pair;
		logic      bank;
	} bfly_req_t;

	// engine result, tag copied from the job
	typedef struct packed {
		sample_t   sum;
		sample_t   diff;
		pair_idx_t pair;
		logic      bank;
	} bfly_rsp_t;

endpackage

`default_nettype wire

// File: source/mrd_ctrl_fsm.sv
// ----------------------------------------------------------------------
// ping-pong control
// sw_in picks the sink bank, sw_out picks the source bank
// source_go issue keeps frames in arrival order
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mrd_ctrl_fsm (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire mrd_ctrl_pkg::bank_stat_t stat0,
	input  wire mrd_ctrl_pkg::bank_stat_t stat1,
	output mrd_ctrl_pkg::bank_ctrl_t      ctrl0,
	output mrd_ctrl_pkg::bank_ctrl_t      ctrl1,
	output logic                          sw_in,
	output logic                          sw_out
);

	// a source is granted and has not reached its last sample
	logic src_busy;
	logic go0_q;
	logic go1_q;
	logic sink_done_sel;
	logic ready_sel;
	logic src_end_sel;

	// only the bank each switch points to is looked at
	assign sink_done_sel = sw_in  ? stat1.sink_done  : stat0.sink_done;
	assign ready_sel     = sw_out ? stat1.ready      : stat0.ready;
	assign src_end_sel   = sw_out ? stat1.source_end : stat0.source_end;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sw_in    <= 1'b0;
			sw_out   <= 1'b0;
			src_busy <= 1'b0;
			go0_q    <= 1'b0;
			go1_q    <= 1'b0;
		end else begin
			// input moves to the peer bank once the frame is in
			if (sink_done_sel) begin
				sw_in <= ~sw_in;
			end

			// source_go is a one-cycle pulse
			go0_q <= 1'b0;
			go1_q <= 1'b0;
			if (src_busy) begin
				// output moves on after the last sample
				if (src_end_sel) begin
					src_busy <= 1'b0;
					sw_out   <= ~sw_out;
				end
			end else if (ready_sel) begin
				src_busy <= 1'b1;
				go0_q    <= ~sw_out;
				go1_q    <= sw_out;
			end
		end
	end

	assign ctrl0.sink_sel  = ~sw_in;
	assign ctrl1.sink_sel  = sw_in;
	assign ctrl0.source_go = go0_q;
	assign ctrl1.source_go = go1_q;

endmodule

`default_nettype wire

// File: source/mrd_ctrl_pkg.sv
// ----------------------------------------------------------------------
// control types between the frame banks and the ping-pong FSM
// bank phase encoding
// bank status struct and FSM control struct
// ----------------------------------------------------------------------

`default_nettype none

package mrd_ctrl_pkg;

	// bank life cycle, one frame at a time
	// IDLE     waiting for in_sop while selected for input
	// SINK     frame being written
	// COMPUTE  butterfly jobs in flight through the shared engine
	// READY    frame computed, waiting for its turn on the output
	// SOURCE   frame streaming out
	typedef enum logic [2:0] {
		IDLE,
		SINK,
		COMPUTE,
		READY,
		SOURCE
	} bank_phase_e;

	// bank -> FSM
	typedef struct packed {
		logic sink_sop;
		logic sink_done;
		logic ready;
		logic source_start;
		logic source_end;
	} bank_stat_t;

	// FSM -> bank
	typedef struct packed {
		logic sink_sel;
		logic source_go;
	} bank_ctrl_t;

endpackage

`default_nettype wire

// File: source/mrd_pingpong_top.sv
// ----------------------------------------------------------------------
// ping-pong radix-2 frame processor, top level
// two frame banks, engine arbiter, butterfly engine, control FSM
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mrd_pingpong_top #(
	parameter int DATA_W    = mrd_cfg_pkg::DATA_W,
	parameter int FRAME_PTS = mrd_cfg_pkg::FRAME_PTS
) (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 in_valid,
	input  wire logic                 in_sop,
	input  wire mrd_cfg_pkg::sample_t in_data,
	output logic                      in_ready,
	output logic                      out_valid,
	output logic                      out_sop,
	output mrd_cfg_pkg::sample_t      out_data
);

	mrd_ctrl_pkg::bank_stat_t  stat [2];
	mrd_ctrl_pkg::bank_ctrl_t  ctrl [2];
	mrd_ctrl_pkg::bank_phase_e phase [2];
	mrd_cfg_pkg::bfly_req_t    req [2];
	mrd_cfg_pkg::sample_t      bank_data [2];
	mrd_cfg_pkg::bfly_req_t    eng_req;
	mrd_cfg_pkg::bfly_rsp_t    eng_rsp;
	mrd_cfg_pkg::bfly_rsp_t    rsp;
	logic                      req_valid [2];
	logic                      grant [2];
	logic                      rsp_valid [2];
	logic                      bank_valid [2];
	logic                      bank_sop [2];
	logic                      eng_valid;
	logic                      eng_rsp_valid;
	logic                      sw_in;

	// ------------------------------------------------------------------
	// frame banks
	// ------------------------------------------------------------------
	for (genvar i = 0; i < 2; i++) begin : g_bank
		mrd_bank #(
			.DATA_W    (DATA_W),
			.FRAME_PTS (FRAME_PTS),
			.BANK_ID   (i[0])
		) i_bank (
			.clk       (clk),
			.rst_n     (rst_n),
			.ctrl      (ctrl[i]),
			.stat      (stat[i]),
			.phase     (phase[i]),
			.in_valid  (in_valid),
			.in_sop    (in_sop),
			.in_data   (in_data),
			.req_valid (req_valid[i]),
			.req       (req[i]),
			.grant     (grant[i]),
			.rsp_valid (rsp_valid[i]),
			.rsp       (rsp),
			.out_valid (bank_valid[i]),
			.out_sop   (bank_sop[i]),
			.out_data  (bank_data[i])
		);
	end

	// ------------------------------------------------------------------
	// shared butterfly path
	// ------------------------------------------------------------------
	mrd_bfly_arbiter i_arbiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid0    (req_valid[0]),
		.req_valid1    (req_valid[1]),
		.req0          (req[0]),
		.req1          (req[1]),
		.grant0        (grant[0]),
		.grant1        (grant[1]),
		.eng_valid     (eng_valid),
		.eng_req       (eng_req),
		.eng_rsp_valid (eng_rsp_valid),
		.eng_rsp       (eng_rsp),
		.rsp_valid0    (rsp_valid[0]),
		.rsp_valid1    (rsp_valid[1]),
		.rsp           (rsp)
	);

	mrd_bfly_engine #(
		.DATA_W (DATA_W)
	) i_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (eng_valid),
		.req       (eng_req),
		.rsp_valid (eng_rsp_valid),
		.rsp       (eng_rsp)
	);

	// sw_out stays inside the FSM, only sw_in shapes in_ready
	mrd_ctrl_fsm i_ctrl_fsm (
		.clk    (clk),
		.rst_n  (rst_n),
		.stat0  (stat[0]),
		.stat1  (stat[1]),
		.ctrl0  (ctrl[0]),
		.ctrl1  (ctrl[1]),
		.sw_in  (sw_in),
		.sw_out ()
	);

	// input open while the sink bank is free or mid-frame
	assign in_ready = (phase[sw_in] == mrd_ctrl_pkg::IDLE) |
	                  (phase[sw_in] == mrd_ctrl_pkg::SINK);

	// at most one bank sources at a time, idle outputs are zero
	assign out_valid = bank_valid[0] | bank_valid[1];
	assign out_sop   = bank_sop[0] | bank_sop[1];
	assign out_data  = bank_data[0] | bank_data[1];

endmodule

`default_nettype wire

// File: test/mrd_tb.sv
// ----------------------------------------------------------------------
// testbench for the ping-pong radix-2 frame processor
// galois lfsr stimulus, butterfly frame model with expected queue
// output monitor with compare tasks, per-wait cycle timeouts
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mrd_tb;

	localparam int DATA_W        = 16;
	localparam int FRAME_PTS     = 16;
	localparam int SINK_TIMEOUT  = 400;
	localparam int DRAIN_TIMEOUT = 600;
	localparam mrd_cfg_pkg::sample_t MAX_POS = mrd_cfg_pkg::sample_t'({1'b0, {(DATA_W-1){1'b1}}});
	localparam mrd_cfg_pkg::sample_t MAX_NEG = mrd_cfg_pkg::sample_t'({1'b1, {(DATA_W-1){1'b0}}});

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_sop;
	mrd_cfg_pkg::sample_t in_data;
	logic                 in_ready;
	logic                 out_valid;
	logic                 out_sop;
	mrd_cfg_pkg::sample_t out_data;

	logic [31:0]          lfsr_q;
	mrd_cfg_pkg::sample_t frame_buf [FRAME_PTS];
	mrd_cfg_pkg::sample_t exp_q [$];
	int                   out_pos;
	int                   frames_in;
	int                   frames_out;
	int                   full_cycles;

	mrd_pingpong_top #(
		.DATA_W    (DATA_W),
		.FRAME_PTS (FRAME_PTS)
	) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_sop    (in_sop),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// random bits and failure handling
	// ------------------------------------------------------------------
	// right-shift galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// one lfsr step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v      = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	task automatic stop_failed();
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic timeout_fail(input string what);
		$display("timed out at %0t ns while waiting for %s", $time, what);
		stop_failed();
	endtask

	task automatic check_sample(input mrd_cfg_pkg::sample_t got, input mrd_cfg_pkg::sample_t exp,
	                            input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_sop(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: out_sop is %b, expected %b", $time, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_failed();
		end
	endtask

	// ------------------------------------------------------------------
	// frame model and input driver
	// ------------------------------------------------------------------
	task automatic fill_random();
		logic [31:0] r;
		for (int i = 0; i < FRAME_PTS; i++) begin
			rand_bits(DATA_W, r);
			frame_buf[i] = mrd_cfg_pkg::sample_t'(r[DATA_W-1:0]);
		end
	endtask

	// each pair k gives x[2k]+x[2k+1] then x[2k]-x[2k+1], truncated to the sample width
	task automatic model_frame();
		mrd_cfg_pkg::sample_t s;
		mrd_cfg_pkg::sample_t d;
		for (int k = 0; k < FRAME_PTS / 2; k++) begin
			s = frame_buf[2*k] + frame_buf[2*k+1];
			d = frame_buf[2*k] - frame_buf[2*k+1];
			exp_q.push_back(s);
			exp_q.push_back(d);
		end
	endtask

	// a sample counts as taken when in_valid and in_ready are both high mid-cycle
	task automatic send_frame(input bit gaps);
		int          idx;
		int          wait_cyc;
		int          held;
		logic [31:0] r;
		logic        drive;
		model_frame();
		idx      = 0;
		wait_cyc = 0;
		while (idx < FRAME_PTS) begin
			@(posedge clk);
			// whole frames taken in and not yet fully out
			held  = frames_in - frames_out;
			drive = 1'b1;
			if (gaps) begin
				rand_bits(2, r);
				drive = r[1:0] != 2'b00;
			end
			in_valid <= drive;
			in_sop   <= idx == 0;
			in_data  <= frame_buf[idx];
			@(negedge clk);
			// two held frames fill both banks, so no input can be taken
			if (held >= 2) begin
				check_level(in_ready, 1'b0, "in_ready with both banks holding frames");
				full_cycles++;
			end
			if (in_valid && in_ready) begin
				idx++;
				wait_cyc = 0;
			end else begin
				wait_cyc++;
				if (wait_cyc > SINK_TIMEOUT) begin
					timeout_fail("in_ready to accept the next input sample");
				end
			end
		end
		frames_in++;
	endtask

	task automatic idle_input();
		@(posedge clk);
		in_valid <= 1'b0;
		in_sop   <= 1'b0;
	endtask

	task automatic wait_drain();
		int cnt;
		cnt = 0;
		while (exp_q.size() != 0 || out_pos != 0) begin
			@(posedge clk);
			cnt++;
			if (cnt > DRAIN_TIMEOUT) begin
				timeout_fail("all expected output samples");
			end
		end
	endtask

	// ------------------------------------------------------------------
	// output monitor, sampled mid-cycle
	// ------------------------------------------------------------------
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("output sample at %0t ns arrived with no frame outstanding", $time);
					stop_failed();
				end
				check_sop(out_sop, out_pos == 0);
				check_sample(out_data, exp_q.pop_front(), "out_data");
				out_pos++;
				if (out_pos == FRAME_PTS) begin
					out_pos = 0;
					frames_out++;
				end
			end else if (out_pos != 0) begin
				$display("output frame broken by an idle cycle at %0t ns", $time);
				stop_failed();
			end
		end
	end

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		lfsr_q      = 32'h5d4bdf13;
		out_pos     = 0;
		frames_in   = 0;
		frames_out  = 0;
		full_cycles = 0;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_sop      = 1'b0;
		in_data     = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_level(out_valid, 1'b0, "out_valid after reset");
		check_level(in_ready, 1'b1, "in_ready after reset");

		// single frame, then the same data again with input gaps
		fill_random();
		send_frame(1'b0);
		idle_input();
		wait_drain();
		send_frame(1'b1);
		idle_input();
		wait_drain();

		// back-to-back frames at the rate in_ready allows
		for (int f = 0; f < 8; f++) begin
			fill_random();
			send_frame(f >= 6);
		end
		idle_input();
		wait_drain();

		// extreme operands wrap in both sum and diff
		fill_random();
		frame_buf[0] = MAX_POS;
		frame_buf[1] = MAX_NEG;
		frame_buf[2] = MAX_NEG;
		frame_buf[3] = MAX_POS;
		frame_buf[4] = MAX_NEG;
		frame_buf[5] = MAX_NEG;
		frame_buf[6] = MAX_POS;
		frame_buf[7] = MAX_POS;
		send_frame(1'b0);
		idle_input();
		wait_drain();

		if (frames_out == frames_in && full_cycles > 0) begin
			$display("all tests passed");
		end else begin
			$display("frame count mismatch or both banks never held frames: in %0d, out %0d",
			         frames_in, frames_out);
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
source/mrd_cfg_pkg.sv
source/mrd_ctrl_pkg.sv
source/mrd_bfly_engine.sv
source/mrd_bfly_arbiter.sv
source/mrd_bank.sv
source/mrd_ctrl_fsm.sv
source/mrd_pingpong_top.sv
test/mrd_tb.sv
